// File: hdl/mtx_config.svh
//########################################
// mtx link configuration
// sizes shared by the transmit path:
// io word width, queue depth, and the
// depth of the clock crossing flops
//########################################

`ifndef MTX_CONFIG_SVH
`define MTX_CONFIG_SVH

`default_nettype none

//########################################
// io word
//########################################

`define MTX_IOW 64 // full io data word in bits, 8 byte lanes

//########################################
// queues and synchronizers
//########################################

// entries per source queue
// also the credit count a source starts with
`define MTX_FIFO_DEPTH 4

`define MTX_SYNC_STAGES 2 // flops per synchronizer chain

`default_nettype wire

`endif

// File: hdl/mtx_pkg.sv
//########################################
// mtx link types
// lane width encoding, static link
// configuration and the core packet
//########################################

`include "mtx_config.svh"

`default_nettype none

package mtx_pkg;

   //########################################
   // lane width
   //########################################

   // lane group width on the io side
   typedef enum logic [1:0] {
      W8  = 2'b00, // one byte lane
      W16 = 2'b01,
      W32 = 2'b10,
      W64 = 2'b11  // whole word, sdr only
   } mtx_width_e;

   // static link setup, change only while idle
   typedef struct packed {
      logic       ddr_mode; // both clock edges carry data
      mtx_width_e iowidth;  // lane group width
   } mtx_cfg_t;

   //########################################
   // core packet
   //########################################

   // valid is thermometer from byte 0, zero means empty word
   typedef struct packed {
      logic [`MTX_IOW/8-1:0] valid; // one bit per byte
      logic [`MTX_IOW-1:0]   data;
   } mtx_packet_t;

endpackage

`default_nettype wire

// File: hdl/mtx_sync.sv
//########################################
// mtx io clock synchronizers
// reset: async assert, sync release
// wait: level sync from the far end
//########################################

`include "mtx_config.svh"

`timescale 1ns/1ps
`default_nettype none

module mtx_sync (
   input  wire  io_clk,
   input  wire  nreset,    // raw reset, any domain
   output logic io_nreset, // reset for the io domain
   input  wire  tx_wait,   // async from far end
   output logic io_wait
);

   localparam int STAGES = `MTX_SYNC_STAGES;

   logic [STAGES-1:0] rst_sync; // ones shift in after release
   logic [STAGES-1:0] wait_sync;

   //########################################
   // reset
   //########################################

   always_ff @(posedge io_clk or negedge nreset) begin
      if (!nreset) begin
         rst_sync <= '0; // assert at once
      end else begin
         rst_sync <= {rst_sync[STAGES-2:0], 1'b1};
      end
   end

   assign io_nreset = rst_sync[STAGES-1];

   // wait chain, same depth so io_wait lags tx_wait by STAGES edges
   always_ff @(posedge io_clk or negedge io_nreset) begin
      if (!io_nreset) begin
         wait_sync <= '0;
      end else begin
         wait_sync <= {wait_sync[STAGES-2:0], tx_wait};
      end
   end

   assign io_wait = wait_sync[STAGES-1];

endmodule

`default_nettype wire

// File: hdl/mtx_fifo.sv
//########################################
// mtx source queue
// circular buffer per core source
// one credit pulse back per word handed
// on, empty words dropped at the input
//########################################

`include "mtx_config.svh"

`timescale 1ns/1ps
`default_nettype none

module mtx_fifo (
   input  wire                  io_clk,
   input  wire                  io_nreset,
   input  wire                  src_push,
   input  mtx_pkg::mtx_packet_t src_packet,
   output logic                 src_credit, // one word freed
   output logic                 q_valid,    // head available
   output mtx_pkg::mtx_packet_t q_packet,
   input  wire                  q_pop       // take head this edge
);

   localparam int DEPTH = `MTX_FIFO_DEPTH;
   localparam int AW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CW    = $clog2(DEPTH + 1); // holds 0..DEPTH

   mtx_pkg::mtx_packet_t mem [DEPTH];
   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [CW-1:0] count;
   logic          wr_en;
   logic          rd_en;
   logic          drop;        // empty mask push
   logic [CW-1:0] credit_pend; // credits still owed
   logic [CW:0]   credit_sum;

   assign wr_en = src_push && (|src_packet.valid) && (count != CW'(DEPTH));
   assign drop  = src_push && !(|src_packet.valid);
   assign rd_en = q_pop && (count != '0);

   // storage, no reset needed on payload
   always_ff @(posedge io_clk) begin
      if (wr_en) begin
         mem[wr_ptr] <= src_packet;
      end
   end

   always_ff @(posedge io_clk or negedge io_nreset) begin
      if (!io_nreset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_en) begin
            wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1; // wrap
         end
         if (rd_en) begin
            rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         count <= count + CW'(wr_en) - CW'(rd_en);
      end
   end

   assign q_valid  = (count != '0);
   assign q_packet = mem[rd_ptr];

   //########################################
   // credit return
   //########################################

   // pop and drop can land together, the spare credit goes out next cycle
   assign credit_sum = (CW+1)'(credit_pend) + (CW+1)'(rd_en) + (CW+1)'(drop);

   always_ff @(posedge io_clk or negedge io_nreset) begin
      if (!io_nreset) begin
         src_credit  <= 1'b0;
         credit_pend <= '0;
      end else begin
         src_credit  <= |credit_sum; // single pulse per cycle
         credit_pend <= CW'(credit_sum - (CW+1)'(|credit_sum));
      end
   end

endmodule

`default_nettype wire

// File: hdl/mtx_arbiter.sv
//########################################
// mtx round-robin arbiter
// shares the serializer between the two
// source queues, grant is combinational
//########################################

`timescale 1ns/1ps
`default_nettype none

module mtx_arbiter (
   input  wire                  io_clk,
   input  wire                  io_nreset,
   input  wire  [1:0]           q_valid,
   input  mtx_pkg::mtx_packet_t q_packet0,
   input  mtx_pkg::mtx_packet_t q_packet1,
   output logic [1:0]           q_pop,  // one-hot or zero
   input  wire                  ready,  // serializer idle, no wait
   output logic                 load,
   output mtx_pkg::mtx_packet_t load_packet
);

   logic [1:0] req;
   logic [1:0] gnt;
   logic       prio; // 0: source 0 wins a tie

   assign req = q_valid & {2{ready}};

   //########################################
   // grant
   //########################################

   always_comb begin
      if (req == 2'b11) begin
         gnt = prio ? 2'b10 : 2'b01; // tie, priority decides
      end else begin
         gnt = req; // lone requester, whatever the priority
      end
   end

   assign q_pop       = gnt;
   assign load        = |gnt;
   assign load_packet = gnt[1] ? q_packet1 : q_packet0; // steer granted head

   // priority passes to the other side after each grant
   always_ff @(posedge io_clk or negedge io_nreset) begin
      if (!io_nreset) begin
         prio <= 1'b0;
      end else if (load) begin
         prio <= gnt[0];
      end
   end

endmodule

`default_nettype wire

// File: hdl/mtx_io.sv
//########################################
// mtx transmit serializer
// shifts a word out over 8..64 bit lane
// groups, lower bytes first, with access
// strobe and sdr or ddr output stage
//########################################

`include "mtx_config.svh"

`timescale 1ns/1ps
`default_nettype none

module mtx_io (
   input  wire                  io_clk,
   input  wire                  io_nreset,
   input  mtx_pkg::mtx_cfg_t    cfg,
   input  wire                  load,
   input  mtx_pkg::mtx_packet_t load_packet,
   output logic                 ready,      // can take a word
   input  wire                  io_wait,    // synced far end wait
   output logic [`MTX_IOW-1:0]  tx_packet,
   output logic                 tx_access
);

   localparam int IOW = `MTX_IOW;
   localparam int NB  = IOW/8; // byte lanes

   logic [IOW-1:0]   shiftreg;
   logic [NB-1:0]    valid_reg;     // bytes still to send
   logic             active;
   logic [1:0]       grp_sel;       // log2 of bytes per beat
   logic [NB-1:0]    grp_mask;
   logic [NB-1:0]    beat_mask;
   logic [IOW-1:0]   beat_data;
   logic [IOW-1:0]   beat_reg;      // first output stage
   logic             beat_access;
   logic [IOW-1:0]   tx_packet_sdr;
   logic [IOW/2-1:0] lane_mask;
   logic [IOW-1:0]   beat_upper;
   logic [IOW/2-1:0] lane_lo;
   logic [IOW/2-1:0] lane_hi;
   logic [IOW/2-1:0] ddr_q1;        // rising edge half
   logic [IOW/2-1:0] ddr_q2;
   logic [IOW/2-1:0] ddr_q2_neg;    // falling edge half
   logic [IOW/2-1:0] tx_packet_ddr;

   //########################################
   // beat sizing
   //########################################

   // ddr moves two lane groups per cycle
   always_comb begin
      if (!cfg.ddr_mode) begin
         grp_sel = cfg.iowidth;
      end else if (cfg.iowidth == mtx_pkg::W64) begin
         grp_sel = 2'd3; // not a legal ddr setting, send whole word
      end else begin
         grp_sel = cfg.iowidth + 2'd1;
      end
   end

   always_comb begin
      case (grp_sel)
         2'd0:    grp_mask = NB'(8'h01);
         2'd1:    grp_mask = NB'(8'h03);
         2'd2:    grp_mask = NB'(8'h0f);
         default: grp_mask = NB'(8'hff);
      endcase
   end

   assign active    = |valid_reg;
   assign ready     = !active && !io_wait; // wait only blocks the next word
   assign beat_mask = valid_reg & grp_mask;

   // invalid bytes go out as zero
   always_comb begin
      for (int i = 0; i < NB; i++) begin
         beat_data[8*i +: 8] = beat_mask[i] ? shiftreg[8*i +: 8] : 8'h00;
      end
   end

   //########################################
   // shift down
   //########################################

   always_ff @(posedge io_clk or negedge io_nreset) begin
      if (!io_nreset) begin
         valid_reg <= '0;
      end else if (load && ready) begin
         valid_reg <= load_packet.valid;
      end else if (active) begin
         valid_reg <= valid_reg >> (1 << grp_sel); // one beat of bytes
      end
   end

   always_ff @(posedge io_clk) begin
      if (load && ready) begin
         shiftreg <= load_packet.data;
      end else if (active) begin
         shiftreg <= shiftreg >> (8 << grp_sel);
      end
   end

   // two stage pipe, access follows the data
   always_ff @(posedge io_clk or negedge io_nreset) begin
      if (!io_nreset) begin
         beat_access <= 1'b0;
         tx_access   <= 1'b0;
      end else begin
         beat_access <= active;
         tx_access   <= beat_access;
      end
   end

   always_ff @(posedge io_clk) begin
      beat_reg      <= beat_data;
      tx_packet_sdr <= beat_reg; // sdr output register
   end

   //########################################
   // ddr output
   //########################################

   always_comb begin
      case (cfg.iowidth)
         mtx_pkg::W8:  lane_mask = (IOW/2)'(32'h0000_00ff);
         mtx_pkg::W16: lane_mask = (IOW/2)'(32'h0000_ffff);
         default:      lane_mask = '1;
      endcase
   end

   assign beat_upper = beat_reg >> (8 << cfg.iowidth); // second lane group
   assign lane_lo    = beat_reg[IOW/2-1:0] & lane_mask;
   assign lane_hi    = beat_upper[IOW/2-1:0] & lane_mask;

   // behavioural ddr register, both halves taken on the rising edge
   always_ff @(posedge io_clk) begin
      ddr_q1 <= lane_lo;
      ddr_q2 <= lane_hi;
   end

   always_ff @(negedge io_clk) begin
      ddr_q2_neg <= ddr_q2; // upper half held over the low phase
   end

   assign tx_packet_ddr = io_clk ? ddr_q1 : ddr_q2_neg;

   assign tx_packet = cfg.ddr_mode ? {{(IOW/2){1'b0}}, tx_packet_ddr} : tx_packet_sdr;

endmodule

`default_nettype wire

// File: hdl/mtx_top.sv
//########################################
// mtx transmit subsystem
// two credit queues, round-robin arbiter
// and lane serializer on the io clock
//########################################

`timescale 1ns/1ps
`default_nettype none

module mtx_top (
   input  wire                  io_clk,
   input  wire                  nreset,      // raw, synced below
   input  mtx_pkg::mtx_cfg_t    cfg,
   input  wire  [1:0]           src_push,
   input  mtx_pkg::mtx_packet_t src_packet0,
   input  mtx_pkg::mtx_packet_t src_packet1,
   output logic [1:0]           src_credit,
   output logic [63:0]          tx_packet,
   output logic                 tx_access,
   input  wire                  tx_wait
);

   logic                 io_nreset;
   logic                 io_wait;
   logic [1:0]           q_valid;
   logic [1:0]           q_pop;
   mtx_pkg::mtx_packet_t q_packet0;
   mtx_pkg::mtx_packet_t q_packet1;
   logic                 load;
   logic                 ready;
   mtx_pkg::mtx_packet_t load_packet;

   mtx_sync mtx_sync_inst (
      .io_clk    (io_clk),
      .nreset    (nreset),
      .io_nreset (io_nreset),
      .tx_wait   (tx_wait),
      .io_wait   (io_wait)
   );

   // source queues, peers
   mtx_fifo fifo0_inst (
      .io_clk     (io_clk),
      .io_nreset  (io_nreset),
      .src_push   (src_push[0]),
      .src_packet (src_packet0),
      .src_credit (src_credit[0]),
      .q_valid    (q_valid[0]),
      .q_packet   (q_packet0),
      .q_pop      (q_pop[0])
   );

   mtx_fifo fifo1_inst (
      .io_clk     (io_clk),
      .io_nreset  (io_nreset),
      .src_push   (src_push[1]),
      .src_packet (src_packet1),
      .src_credit (src_credit[1]),
      .q_valid    (q_valid[1]),
      .q_packet   (q_packet1),
      .q_pop      (q_pop[1])
   );

   mtx_arbiter mtx_arbiter_inst (
      .io_clk      (io_clk),
      .io_nreset   (io_nreset),
      .q_valid     (q_valid),
      .q_packet0   (q_packet0),
      .q_packet1   (q_packet1),
      .q_pop       (q_pop),
      .ready       (ready),
      .load        (load),
      .load_packet (load_packet)
   );

   mtx_io mtx_io_inst (
      .io_clk      (io_clk),
      .io_nreset   (io_nreset),
      .cfg         (cfg),
      .load        (load),
      .load_packet (load_packet),
      .ready       (ready),
      .io_wait     (io_wait),
      .tx_packet   (tx_packet),
      .tx_access   (tx_access)
   );

endmodule

`default_nettype wire

// File: verification/mtx_checker.sv
//########################################
// mtx transmit checker
// concurrent assertions on the top level
// reset quiet, one pop, busy serializer
//########################################

`timescale 1ns/1ps
`default_nettype none

module mtx_checker (
   input wire       io_clk,
   input wire       io_nreset,
   input wire       tx_access,
   input wire [1:0] q_pop,
   input wire       load,
   input wire       ready
);

   // no strobe while the io domain is held in reset
   assert property (@(posedge io_clk) !io_nreset |-> !tx_access)
      else $error("tx_access high during reset");

   assert property (@(posedge io_clk) disable iff (!io_nreset) !(q_pop[0] && q_pop[1]))
      else $error("q_pop granted to both queues");

   // an accepted word keeps the serializer busy next cycle
   assert property (@(posedge io_clk) disable iff (!io_nreset) (load && ready) |=> !ready)
      else $error("ready high during a word");

endmodule

bind mtx_top mtx_checker mtx_checker_inst (
   .io_clk    (io_clk),
   .io_nreset (io_nreset),
   .tx_access (tx_access),
   .q_pop     (q_pop),
   .load      (load),
   .ready     (ready)
);

`default_nettype wire

// File: verification/mtx_tb.sv
//########################################
// mtx transmit testbench
// table driven pushes, beat reference
// model, word and credit checks
//########################################

`include "mtx_config.svh"

`timescale 1ns/1ps
`default_nettype none

module mtx_tb;

   localparam int LIMIT = 4000; // cycles per wait loop
   localparam int NUM   = 26;

   typedef struct packed {
      logic                src;
      logic [7:0]          mask;  // thermometer valid
      mtx_pkg::mtx_width_e width;
      logic                ddr;
      logic                hold;  // part of a held-wait batch
   } entry_t;

   //########################################
   // stimulus table
   //########################################

   entry_t tbl [NUM] = '{
      '{1'b0, 8'hff, mtx_pkg::W16, 1'b0, 1'b1}, // both queues filled under wait
      '{1'b0, 8'h3f, mtx_pkg::W16, 1'b0, 1'b1},
      '{1'b1, 8'hff, mtx_pkg::W16, 1'b0, 1'b1},
      '{1'b0, 8'h0f, mtx_pkg::W16, 1'b0, 1'b1},
      '{1'b1, 8'h7f, mtx_pkg::W16, 1'b0, 1'b1},
      '{1'b1, 8'h03, mtx_pkg::W16, 1'b0, 1'b1},
      '{1'b0, 8'h01, mtx_pkg::W16, 1'b0, 1'b1}, // queue 0 now at depth
      '{1'b1, 8'h1f, mtx_pkg::W16, 1'b0, 1'b1}, // queue 1 now at depth
      '{1'b0, 8'hff, mtx_pkg::W8,  1'b0, 1'b0}, // sdr singles
      '{1'b1, 8'h07, mtx_pkg::W8,  1'b0, 1'b0},
      '{1'b0, 8'h1f, mtx_pkg::W16, 1'b0, 1'b0},
      '{1'b1, 8'hff, mtx_pkg::W32, 1'b0, 1'b0},
      '{1'b0, 8'h07, mtx_pkg::W32, 1'b0, 1'b0},
      '{1'b1, 8'hff, mtx_pkg::W64, 1'b0, 1'b0},
      '{1'b0, 8'h01, mtx_pkg::W64, 1'b0, 1'b0},
      '{1'b0, 8'h00, mtx_pkg::W8,  1'b0, 1'b0}, // empty word
      '{1'b1, 8'hff, mtx_pkg::W8,  1'b1, 1'b0}, // ddr singles
      '{1'b0, 8'h07, mtx_pkg::W8,  1'b1, 1'b0},
      '{1'b1, 8'hff, mtx_pkg::W16, 1'b1, 1'b0},
      '{1'b0, 8'h07, mtx_pkg::W16, 1'b1, 1'b0},
      '{1'b1, 8'hff, mtx_pkg::W32, 1'b1, 1'b0},
      '{1'b0, 8'h1f, mtx_pkg::W32, 1'b1, 1'b0},
      '{1'b1, 8'h0f, mtx_pkg::W32, 1'b1, 1'b1}, // lone queue batch
      '{1'b1, 8'hff, mtx_pkg::W32, 1'b1, 1'b1},
      '{1'b1, 8'h01, mtx_pkg::W32, 1'b1, 1'b1},
      '{1'b1, 8'h00, mtx_pkg::W32, 1'b1, 1'b1}
   };

   logic                 io_clk;
   logic                 nreset;
   mtx_pkg::mtx_cfg_t    cfg;
   logic [1:0]           src_push;
   mtx_pkg::mtx_packet_t src_packet0;
   mtx_pkg::mtx_packet_t src_packet1;
   logic [1:0]           src_credit;
   logic [63:0]          tx_packet;
   logic                 tx_access;
   logic                 tx_wait;

   int seed = 66;
   int pushes [2];
   int credits [2];
   int prio_src;      // source that wins a tie next
   bit hold_window;   // no strobe allowed
   int word_pos;      // byte offset in word being seen
   int beat_errors;
   int packet_errors;
   int credit_errors;
   int other_errors;
   mtx_pkg::mtx_packet_t cur_word;
   logic [63:0]          exp_beats [$];
   logic [63:0]          obs_beats [$];
   mtx_pkg::mtx_packet_t exp_words [$];
   mtx_pkg::mtx_packet_t obs_words [$];

   mtx_top mtx_top_inst (
      .io_clk      (io_clk),
      .nreset      (nreset),
      .cfg         (cfg),
      .src_push    (src_push),
      .src_packet0 (src_packet0),
      .src_packet1 (src_packet1),
      .src_credit  (src_credit),
      .tx_packet   (tx_packet),
      .tx_access   (tx_access),
      .tx_wait     (tx_wait)
   );

   initial begin
      io_clk = 1'b0;
      forever #50 io_clk = ~io_clk;
   end

   //########################################
   // compare tasks
   //########################################

   task automatic check_beat(input string name, input logic [63:0] exp, input logic [63:0] got);
      if (got !== exp) begin
         $display("Fail %0t %s expected %h got %h", $time, name, exp, got);
         beat_errors++;
      end
   endtask

   task automatic check_credit(input string name, input int exp, input int got);
      if (got != exp) begin
         $display("Fail %0t %s expected %0d got %0d", $time, name, exp, got);
         credit_errors++;
      end
   endtask

   task automatic check_packet(input string name, input mtx_pkg::mtx_packet_t exp,
                               input mtx_pkg::mtx_packet_t got);
      if (got !== exp) begin
         $display("Fail %0t %s expected %h got %h", $time, name, exp, got);
         packet_errors++;
      end
   endtask

   task automatic report_and_finish();
      int total;
      total = beat_errors + packet_errors + credit_errors + other_errors;
      $display("errors: beat %0d, packet %0d, credit %0d, other %0d",
               beat_errors, packet_errors, credit_errors, other_errors);
      if (total == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   endtask

   task automatic give_up(input string what);
      $display("Timeout while waiting for %s", what);
      other_errors++;
      report_and_finish();
   endtask

   task automatic wait_cycles(input int n);
      repeat (n) @(posedge io_clk);
      #10; // drive point
   endtask

   //########################################
   // reference beat model
   //########################################

   // one sample per sdr beat, two per ddr beat, L bytes each
   task automatic expand_word(input mtx_pkg::mtx_packet_t pkt);
      int lb;
      int unit;
      int n;
      int samples;
      int idx;
      logic [63:0] beat;
      mtx_pkg::mtx_packet_t word;
      lb   = 1 << cfg.iowidth;
      unit = cfg.ddr_mode ? 2 * lb : lb;
      n    = $countones(pkt.valid);
      samples = (n + unit - 1) / unit;
      if (cfg.ddr_mode) samples = 2 * samples;
      word = '0;
      for (int j = 0; j < samples; j++) begin
         beat = '0;
         for (int b = 0; b < lb; b++) begin
            idx = j * lb + b;
            if (idx < 8) begin
               word.valid[idx] = 1'b1; // covered by a lane
               if (pkt.valid[idx]) begin
                  beat[8*b +: 8]      = pkt.data[8*idx +: 8];
                  word.data[8*idx +: 8] = pkt.data[8*idx +: 8];
               end
            end
         end
         exp_beats.push_back(beat);
      end
      exp_words.push_back(word);
   endtask

   //########################################
   // monitor
   //########################################

   task automatic take_lanes(input logic [63:0] val);
      int lb;
      lb = 1 << cfg.iowidth;
      for (int b = 0; b < lb; b++) begin
         if (word_pos + b < 8) begin
            cur_word.data[8*(word_pos+b) +: 8] = val[8*b +: 8];
            cur_word.valid[word_pos+b]         = 1'b1;
         end
      end
      word_pos += lb;
      obs_beats.push_back(val);
   endtask

   initial begin
      forever begin
         @(posedge io_clk);
         #25; // mid high phase
         if (src_credit[0]) credits[0]++;
         if (src_credit[1]) credits[1]++;
         if (tx_access) begin
            if (hold_window) begin
               $display("tx_access went high at %0t while tx_wait was held", $time);
               other_errors++;
            end
            take_lanes(tx_packet);
            if (cfg.ddr_mode) begin
               @(negedge io_clk);
               #25; // low phase carries upper group half
               take_lanes(tx_packet);
            end
         end else if (word_pos > 0) begin
            obs_words.push_back(cur_word); // gap ends the word
            cur_word = '0;
            word_pos = 0;
         end
      end
   end

   //########################################
   // stimulus
   //########################################

   task automatic run_group(input int first, input int last);
      mtx_pkg::mtx_packet_t q0 [$];
      mtx_pkg::mtx_packet_t q1 [$];
      mtx_pkg::mtx_packet_t pkt;
      int src;
      int cnt;
      cfg.ddr_mode = tbl[first].ddr; // link idle here
      cfg.iowidth  = tbl[first].width;
      if (tbl[first].hold) begin
         tx_wait = 1'b1;
         wait_cycles(4); // past the sync chain
         hold_window = 1'b1;
      end
      for (int i = first; i < last; i++) begin
         src = int'(tbl[i].src);
         cnt = 0;
         while (pushes[src] - credits[src] >= `MTX_FIFO_DEPTH) begin
            wait_cycles(1);
            cnt++;
            if (cnt > LIMIT) give_up("a source credit");
         end
         pkt.valid = tbl[i].mask;
         pkt.data  = {$random(seed), $random(seed)};
         if (src == 0) begin
            src_packet0 = pkt;
            src_push    = 2'b01;
            if (|pkt.valid) q0.push_back(pkt);
         end else begin
            src_packet1 = pkt;
            src_push    = 2'b10;
            if (|pkt.valid) q1.push_back(pkt);
         end
         pushes[src]++;
         wait_cycles(1);
         src_push = 2'b00;
      end
      if (tbl[first].hold) begin
         wait_cycles(6);
         hold_window = 1'b0;
         tx_wait     = 1'b0;
      end
      // round robin, lone requester always wins
      while (q0.size() + q1.size() > 0) begin
         if (q1.size() == 0 || (q0.size() > 0 && prio_src == 0)) begin
            expand_word(q0.pop_front());
            prio_src = 1;
         end else begin
            expand_word(q1.pop_front());
            prio_src = 0;
         end
      end
      cnt = 0;
      while (obs_words.size() < exp_words.size()) begin
         wait_cycles(1);
         cnt++;
         if (cnt > LIMIT) give_up("the words of a group");
      end
      wait_cycles(8); // drained, credits back
      if (obs_words.size() != exp_words.size() || obs_beats.size() != exp_beats.size()) begin
         $display("Wrong amount of output at %0t: %0d words %0d beats, expected %0d words %0d beats",
                  $time, obs_words.size(), obs_beats.size(), exp_words.size(), exp_beats.size());
         other_errors++;
      end
      for (int i = 0; i < exp_words.size() && i < obs_words.size(); i++) begin
         check_packet("word", exp_words[i], obs_words[i]);
      end
      for (int i = 0; i < exp_beats.size() && i < obs_beats.size(); i++) begin
         check_beat("tx_packet", exp_beats[i], obs_beats[i]);
      end
      check_credit("src_credit[0] total", pushes[0], credits[0]);
      check_credit("src_credit[1] total", pushes[1], credits[1]);
      exp_words.delete();
      obs_words.delete();
      exp_beats.delete();
      obs_beats.delete();
   endtask

   initial begin
      int idx;
      int first;
      nreset      = 1'b0;
      cfg         = '0;
      src_push    = 2'b00;
      src_packet0 = '0;
      src_packet1 = '0;
      tx_wait     = 1'b0;
      cur_word    = '0;
      repeat (10) @(posedge io_clk);
      #10;
      nreset = 1'b1;
      wait_cycles(5); // reset sync release
      idx = 0;
      while (idx < NUM) begin
         first = idx;
         if (tbl[idx].hold) begin
            while (idx < NUM && tbl[idx].hold) idx++; // held entries form a batch
         end else begin
            idx++;
         end
         run_group(first, idx);
      end
      report_and_finish();
   end

endmodule

`default_nettype wire

// File: list.f
+incdir+hdl
hdl/mtx_pkg.sv
hdl/mtx_sync.sv
hdl/mtx_fifo.sv
hdl/mtx_arbiter.sv
hdl/mtx_io.sv
hdl/mtx_top.sv
verification/mtx_checker.sv
verification/mtx_tb.sv

// File: Makefile
# Verilator build and run of the mtx transmit testbench

VERILATOR ?= verilator
TOP       ?= mtx_tb
BUILD     ?= obj_dir
FILELIST  ?= list.f
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Simulation finished: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)
	@out="$$(./$(BUILD)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD)
